// File: hw/gomoku_settings.svh
`ifndef GOMOKU_SETTINGS_SVH
`define GOMOKU_SETTINGS_SVH

// Board geometry.
`define BOARD_SIZE        15
`define CELL_W            2

`define CELL_BLACK        0
`define CELL_WHITE        1
`define CELL_EMPTY        2

`define WEIGHT_FIVE       1000000
`define WEIGHT_OPEN_FOUR  100000
`define WEIGHT_OPEN_THREE 1000
`define WEIGHT_OPEN_TWO   100

`define LINE_FIFO_DEPTH   4   // Also the scanner's starting credit count.

`endif

// File: hw/gomoku_pkg.sv
`default_nettype none

`include "gomoku_settings.svh"

package gomoku_pkg;

    // One board cell.
    typedef logic [`CELL_W-1:0] cell_t;

    // One vertical line, row 0 in the low bits.
    typedef logic [`BOARD_SIZE*`CELL_W-1:0] column_t;

    // Cell (row, col) sits at index row*BOARD_SIZE + col.
    typedef logic [`BOARD_SIZE*`BOARD_SIZE*`CELL_W-1:0] board_t;

    typedef logic signed [31:0] score_t;

    typedef logic [3:0] col_idx_t;

    // Wide enough to hold the full FIFO depth.
    typedef logic [$clog2(`LINE_FIFO_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

// File: hw/column_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "gomoku_settings.svh"

module column_scanner
    import gomoku_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_start,
    input  wire board_t i_board,
    input  wire logic   i_credit_return,
    output logic        o_busy,
    output logic        o_col_valid,
    output column_t     o_col_data,
    output logic        o_col_last
);

    typedef enum logic {S_IDLE, S_SCAN} scan_state_t;

    scan_state_t state;
    col_idx_t    col_cnt;
    credit_t     credit;
    logic        send;

    assign send        = (state == S_SCAN) && (credit != '0);  // Only with credit in hand.
    assign o_busy      = (state == S_SCAN);
    assign o_col_valid = send;
    assign o_col_last  = (col_cnt == col_idx_t'(`BOARD_SIZE-1));

    // Pick the cells of the current column out of the board.
    always_comb begin
        for (int r = 0; r < `BOARD_SIZE; r++) begin
            o_col_data[r*`CELL_W +: `CELL_W] =
                i_board[(r*`BOARD_SIZE + int'(col_cnt))*`CELL_W +: `CELL_W];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= S_IDLE;
            col_cnt <= '0;
            credit  <= credit_t'(`LINE_FIFO_DEPTH);
        end else begin
            credit <= credit - credit_t'(send) + credit_t'(i_credit_return);
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state <= S_SCAN;  // A start while busy never reaches here.
                    end
                end
                S_SCAN: begin
                    if (send) begin
                        if (o_col_last) begin
                            state   <= S_IDLE;
                            col_cnt <= '0;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Credits come back from the FIFO and must never outnumber its entries.
    a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credit <= credit_t'(`LINE_FIFO_DEPTH))
        else $error("column_scanner credit count above FIFO depth");

endmodule

`default_nettype wire

// File: hw/column_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "gomoku_settings.svh"

module column_fifo
    import gomoku_pkg::*;
#(
    parameter int DEPTH = `LINE_FIFO_DEPTH
) (
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire logic    i_push,
    input  wire column_t i_push_data,
    input  wire logic    i_push_last,
    input  wire logic    i_pop,
    output logic         o_head_valid,
    output column_t      o_head_data,
    output logic         o_head_last,
    output logic         o_credit_return
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    column_t          mem_data [DEPTH];
    logic             mem_last [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push         = i_push && (count != CNT_W'(DEPTH));
    assign do_pop          = i_pop && (count != '0);
    assign o_head_valid    = (count != '0);
    assign o_head_data     = mem_data[rd_ptr];
    assign o_head_last     = mem_last[rd_ptr];
    assign o_credit_return = do_pop;  // One credit back per freed entry.

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem_data[wr_ptr] <= i_push_data;
            mem_last[wr_ptr] <= i_push_last;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // ----------------------------------------
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> (count != CNT_W'(DEPTH)))
        else $error("column_fifo push while full, scanner overran its credits");

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> (count != '0))
        else $error("column_fifo pop while empty");

endmodule

`default_nettype wire

// File: hw/line_scorer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gomoku_settings.svh"

module line_scorer
    import gomoku_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire logic    i_head_valid,
    input  wire column_t i_head_data,
    input  wire logic    i_head_last,
    output logic         o_pop,
    output logic         o_done,
    output score_t       o_score
);

    // Zero padding past the last row, so windows off the board never match.
    localparam int PAD = 5;

    typedef enum logic {S_BLACK, S_WHITE} phase_t;

    phase_t                     phase;
    cell_t                      colour;
    logic [`BOARD_SIZE+PAD-1:0] is_stone;
    logic [`BOARD_SIZE+PAD-1:0] is_empty;
    score_t                     line_sum;
    score_t                     black_acc;
    score_t                     white_acc;

    assign colour = (phase == S_WHITE) ? cell_t'(`CELL_WHITE) : cell_t'(`CELL_BLACK);
    assign o_pop  = (phase == S_WHITE);  // Head stays valid through both phases.

    // ----------------------------------------
    // Per-row classification of the head column.
    always_comb begin
        is_stone = '0;
        is_empty = '0;
        for (int r = 0; r < `BOARD_SIZE; r++) begin
            is_stone[r] = (i_head_data[r*`CELL_W +: `CELL_W] == colour);
            is_empty[r] = (i_head_data[r*`CELL_W +: `CELL_W] == cell_t'(`CELL_EMPTY));
        end
    end

    // ----------------------------------------
    // Match the four open shapes at every start row.
    always_comb begin
        line_sum = '0;
        for (int s = 0; s < `BOARD_SIZE; s++) begin
            if (&is_stone[s +: 5]) begin
                line_sum = line_sum + score_t'(`WEIGHT_FIVE);
            end
            if (is_empty[s] && (&is_stone[s+1 +: 4]) && is_empty[s+5]) begin
                line_sum = line_sum + score_t'(`WEIGHT_OPEN_FOUR);
            end
            if (is_empty[s] && (&is_stone[s+1 +: 3]) && is_empty[s+4]) begin
                line_sum = line_sum + score_t'(`WEIGHT_OPEN_THREE);
            end
            if ((&is_empty[s +: 2]) && (&is_stone[s+2 +: 2]) && (&is_empty[s+4 +: 2])) begin
                line_sum = line_sum + score_t'(`WEIGHT_OPEN_TWO);
            end
        end
    end

    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase     <= S_BLACK;
            black_acc <= '0;
            white_acc <= '0;
            o_done    <= 1'b0;
            o_score   <= '0;
        end else begin
            o_done <= 1'b0;
            case (phase)
                S_BLACK: begin
                    if (i_head_valid) begin
                        black_acc <= black_acc + line_sum;
                        phase     <= S_WHITE;
                    end
                end
                S_WHITE: begin
                    phase <= S_BLACK;
                    if (i_head_last) begin
                        // The board is finished, so publish its score and start the next one clean.
                        o_score   <= black_acc - (white_acc + line_sum);
                        o_done    <= 1'b1;
                        black_acc <= '0;
                        white_acc <= '0;
                    end else begin
                        white_acc <= white_acc + line_sum;
                    end
                end
                default: phase <= S_BLACK;
            endcase
        end
    end

    // The FIFO must hold the head column steady from the black phase to the white one.
    a_head_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (phase == S_WHITE) |->
            (i_head_valid && $stable(i_head_data) && $stable(i_head_last)))
        else $error("line_scorer head column changed between its two phases");

endmodule

`default_nettype wire

// File: hw/board_evaluator.sv
`timescale 1ns/1ps
`default_nettype none

module board_evaluator
    import gomoku_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_start,
    input  wire board_t i_board,
    output logic        o_busy,
    output logic        o_done,
    output score_t      o_score
);

    // Scanner to FIFO.
    logic    col_valid;
    column_t col_data;
    logic    col_last;
    logic    credit_return;

    // FIFO to scorer.
    logic    head_valid;
    column_t head_data;
    logic    head_last;
    logic    head_pop;

    column_scanner u_scanner (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_board         (i_board),
        .i_credit_return (credit_return),
        .o_busy          (o_busy),
        .o_col_valid     (col_valid),
        .o_col_data      (col_data),
        .o_col_last      (col_last)
    );

    column_fifo u_fifo (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_push          (col_valid),
        .i_push_data     (col_data),
        .i_push_last     (col_last),
        .i_pop           (head_pop),
        .o_head_valid    (head_valid),
        .o_head_data     (head_data),
        .o_head_last     (head_last),
        .o_credit_return (credit_return)
    );

    line_scorer u_scorer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head_valid (head_valid),
        .i_head_data  (head_data),
        .i_head_last  (head_last),
        .o_pop        (head_pop),
        .o_done       (o_done),
        .o_score      (o_score)
    );

endmodule

`default_nettype wire

// File: tests/score_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "gomoku_settings.svh"

module score_checker
    import gomoku_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_start,
    input  wire logic   i_busy,
    input  wire board_t i_board,
    input  wire logic   i_done,
    input  wire score_t i_score,
    input  wire logic   i_tbl_valid,
    input  wire score_t i_tbl_score,
    output int          o_errors,
    output int          o_pending
);

    score_t model_q[$];
    logic   tbl_flag_q[$];
    score_t tbl_q[$];
    logic   started;
    logic   done_seen;
    score_t exp_model;
    score_t exp_tbl;
    logic   exp_has_tbl;

    function automatic cell_t cell_at(input board_t b, input int row, input int col);
        return b[(row*`BOARD_SIZE + col)*`CELL_W +: `CELL_W];
    endfunction

    // True when len cells from row downward all hold code; off the board is false.
    function automatic bit run_of(input board_t b, input int col, input int row,
                                  input int len, input int code);
        if (row < 0 || row + len > `BOARD_SIZE) return 0;
        for (int k = 0; k < len; k++) begin
            if (cell_at(b, row + k, col) != cell_t'(code)) return 0;
        end
        return 1;
    endfunction

    // ----------------------------------------
    function automatic int colour_total(input board_t b, input int colour);
        int e;
        int total;
        e = `CELL_EMPTY;
        total = 0;
        for (int c = 0; c < `BOARD_SIZE; c++) begin
            for (int s = 0; s < `BOARD_SIZE; s++) begin
                if (run_of(b, c, s, 5, colour)) total += `WEIGHT_FIVE;
                if (run_of(b, c, s, 1, e) && run_of(b, c, s + 1, 4, colour) &&
                    run_of(b, c, s + 5, 1, e)) total += `WEIGHT_OPEN_FOUR;
                if (run_of(b, c, s, 1, e) && run_of(b, c, s + 1, 3, colour) &&
                    run_of(b, c, s + 4, 1, e)) total += `WEIGHT_OPEN_THREE;
                if (run_of(b, c, s, 2, e) && run_of(b, c, s + 2, 2, colour) &&
                    run_of(b, c, s + 4, 2, e)) total += `WEIGHT_OPEN_TWO;
            end
        end
        return total;
    endfunction

    initial begin
        started   = 1'b0;
        done_seen = 1'b0;
        o_errors  = 0;
        o_pending = 0;
    end

    // ----------------------------------------
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            if (!started && (i_busy || i_done)) begin
                $display("FAILED at %0t: busy or done high before any start", $time);
                o_errors++;
            end
            if (!done_seen && !i_done && i_score != 0) begin
                $display("FAILED at %0t: score %0d before the first result", $time, i_score);
                o_errors++;
            end
            if (i_done) begin
                done_seen = 1'b1;
                if (model_q.size() == 0) begin
                    $display("Done pulsed at %0t while no board was waiting for a result",
                             $time);
                    o_errors++;
                end else begin
                    exp_model   = model_q.pop_front();
                    exp_has_tbl = tbl_flag_q.pop_front();
                    exp_tbl     = tbl_q.pop_front();
                    if (i_score !== exp_model) begin
                        $display("FAILED at %0t: score %0d, model expects %0d",
                                 $time, i_score, exp_model);
                        o_errors++;
                    end
                    if (exp_has_tbl && i_score !== exp_tbl) begin
                        $display("FAILED at %0t: score %0d, table expects %0d",
                                 $time, i_score, exp_tbl);
                        o_errors++;
                    end
                end
            end
            if (i_start && !i_busy) begin  // Only an idle DUT accepts a start.
                model_q.push_back(colour_total(i_board, `CELL_BLACK) -
                                  colour_total(i_board, `CELL_WHITE));
                tbl_flag_q.push_back(i_tbl_valid);
                tbl_q.push_back(i_tbl_score);
                started = 1'b1;
            end
            o_pending = model_q.size();
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_board_evaluator.sv
`timescale 1ns/1ps
`default_nettype none

`include "gomoku_settings.svh"

module tb_board_evaluator
    import gomoku_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int N_TABLE    = 7;
    localparam int N_RANDOM   = 6;
    localparam int N_BOARDS   = N_TABLE + N_RANDOM + 3;
    localparam int TIMEOUT_NS = (N_BOARDS*200 + 10)*CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        start;
    board_t      board;
    logic        busy;
    logic        done;
    score_t      score;
    logic        tbl_valid;
    score_t      tbl_score;
    int          chk_errors;
    int          chk_pending;
    int          tb_errors;
    int          total_errors;
    logic [31:0] lfsr;

    // Table columns: colour, column, first row, length, then the other colour's run.
    int     tbl_first[N_TABLE][4];
    int     tbl_second[N_TABLE][3];
    score_t tbl_exp[N_TABLE];
    int     entries;

    board_evaluator dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_start (start),
        .i_board (board),
        .o_busy  (busy),
        .o_done  (done),
        .o_score (score)
    );

    score_checker u_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_busy      (busy),
        .i_board     (board),
        .i_done      (done),
        .i_score     (score),
        .i_tbl_valid (tbl_valid),
        .i_tbl_score (tbl_score),
        .o_errors    (chk_errors),
        .o_pending   (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before every board produced its result");
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------
    task automatic add_entry(input int colour, input int col, input int row, input int len,
                             input int col2, input int row2, input int len2, input int exp);
        tbl_first[entries]  = '{colour, col, row, len};
        tbl_second[entries] = '{col2, row2, len2};
        tbl_exp[entries]    = exp;
        entries++;
    endtask

    function automatic board_t place_run(input board_t b, input int colour, input int col,
                                         input int row, input int len);
        board_t r;
        r = b;
        for (int i = 0; i < len; i++) begin
            r[((row + i)*`BOARD_SIZE + col)*`CELL_W +: `CELL_W] = cell_t'(colour);
        end
        return r;
    endfunction

    function automatic board_t table_board(input int i);
        board_t b;
        b = '0;
        for (int c = 0; c < `BOARD_SIZE*`BOARD_SIZE; c++) b[c*`CELL_W +: `CELL_W] = `CELL_EMPTY;
        b = place_run(b, tbl_first[i][0], tbl_first[i][1], tbl_first[i][2], tbl_first[i][3]);
        return place_run(b, 1 - tbl_first[i][0], tbl_second[i][0], tbl_second[i][1],
                         tbl_second[i][2]);
    endfunction

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic take_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    task automatic random_board(output board_t b);
        logic [1:0] code;
        for (int i = 0; i < `BOARD_SIZE*`BOARD_SIZE; i++) begin
            code = 2'd3;
            while (code == 2'd3) begin  // Code 3 is no cell, draw again.
                code[1] = take_bit();
                code[0] = take_bit();
            end
            b[i*`CELL_W +: `CELL_W] = code;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_board(input board_t b, input logic with_tbl, input score_t exp);
        while (busy) next_cycle();
        start     = 1'b1;
        board     = b;
        tbl_valid = with_tbl;
        tbl_score = exp;
        next_cycle();
        start     = 1'b0;
        tbl_valid = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < 300) begin
            next_cycle();
            cycles++;
        end
        if (!done) begin
            $display("No done arrived within 300 cycles at %0t", $time);
            tb_errors++;
        end
        next_cycle();
    endtask

    // ----------------------------------------
    initial begin
        board_t b;
        rst_n     = 1'b0;
        start     = 1'b0;
        board     = '0;
        tbl_valid = 1'b0;
        tbl_score = '0;
        tb_errors = 0;
        entries   = 0;
        lfsr      = 32'hfb36_9521;
        add_entry(`CELL_BLACK, 0, 0, 0, 0, 0, 0, 0);
        add_entry(`CELL_BLACK, 3, 0, 5, 0, 0, 0, 1000000);
        add_entry(`CELL_BLACK, 2, 5, 4, 0, 0, 0, 100000);
        add_entry(`CELL_WHITE, 9, 5, 3, 0, 0, 0, -1000);
        add_entry(`CELL_BLACK, 11, 6, 2, 0, 0, 0, 100);
        add_entry(`CELL_BLACK, 3, 0, 5, 9, 5, 3, 999000);
        add_entry(`CELL_BLACK, 0, 10, 5, 14, 2, 4, 900000);
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        for (int i = 0; i < N_TABLE; i++) begin
            apply_board(table_board(i), 1'b1, tbl_exp[i]);
            wait_for_done();
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            random_board(b);
            apply_board(b, 1'b0, '0);
            wait_for_done();
        end
        apply_board(table_board(5), 1'b1, tbl_exp[5]);  // Second start as soon as idle.
        apply_board(table_board(6), 1'b1, tbl_exp[6]);
        wait_for_done();
        wait_for_done();
        random_board(b);
        apply_board(b, 1'b0, '0);
        repeat (4) next_cycle();
        start = 1'b1;  // Busy, so the scanner must ignore it.
        next_cycle();
        start = 1'b0;
        wait_for_done();
        repeat (60) next_cycle();
        if (chk_pending != 0) begin
            $display("%0d started boards never produced a result", chk_pending);
            tb_errors++;
        end
        total_errors = tb_errors + chk_errors;
        $display("Errors: %0d", total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/gomoku_pkg.sv
hw/column_scanner.sv
hw/column_fifo.sv
hw/line_scorer.sv
hw/board_evaluator.sv
tests/score_checker.sv
tests/tb_board_evaluator.sv
